/* src/icache_config.svh */
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// address and instruction word width
`define ICACHE_ADDR_W 32

// direct mapped, one line per index
`define ICACHE_LINES 64

// words fetched from memory per refill
`define ICACHE_WORDS 4

// byte select bits below the word offset
`define ICACHE_BYTE_BITS 2

// tag width follows from the fields below it
`define ICACHE_TAG_W \
    (`ICACHE_ADDR_W - $clog2(`ICACHE_LINES) - $clog2(`ICACHE_WORDS) - `ICACHE_BYTE_BITS)

`endif

/* src/icache_pkg.sv */
`default_nettype none
`include "icache_config.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]          word_t;
    typedef logic [$clog2(`ICACHE_LINES)-1:0]   index_t;
    typedef logic [$clog2(`ICACHE_WORDS)-1:0]   offset_t;
    typedef logic [`ICACHE_TAG_W-1:0]           tag_t;

    // processor fetch port
    typedef struct packed {
        logic  valid;
        word_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic  ready;
        word_t data;
    } fetch_resp_t;

    // memory side, one word per beat
    typedef struct packed {
        logic  valid;
        word_t addr;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        word_t data;
    } mem_resp_t;

    typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, FLUSH} ctrl_state_t;

endpackage

`default_nettype wire

/* src/icache_tag_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_tag_array (
    input  logic               clk,
    input  logic               rst,
    input  icache_pkg::index_t rd_index,
    input  icache_pkg::tag_t   req_tag,
    input  logic               tag_wr,
    input  logic               clear_all,
    output logic               hit
);
    logic [`ICACHE_LINES-1:0] valid_bits;
    icache_pkg::tag_t         tags [`ICACHE_LINES];
    logic                     valid_rd;
    icache_pkg::tag_t         tag_rd;

    // valid bits live in flops so a flush clears them in one cycle
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_bits <= '0;
            valid_rd   <= 1'b0;
        end
        else
        begin
            valid_rd <= valid_bits[rd_index];
            if (clear_all)
                valid_bits <= '0;
            else if (tag_wr)
                valid_bits[rd_index] <= 1'b1;
        end
    end

    // read before write, a new tag shows on the following read
    always_ff @(posedge clk)
    begin
        tag_rd <= tags[rd_index];
        if (tag_wr)
            tags[rd_index] <= req_tag;
    end

    assign hit = valid_rd && (tag_rd == req_tag);

endmodule

`default_nettype wire

/* src/icache_data_array.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_data_array (
    input  logic                clk,
    input  icache_pkg::index_t  rd_index,
    input  icache_pkg::offset_t rd_offset,
    output icache_pkg::word_t   rd_data,
    input  logic                wr_en,
    input  icache_pkg::index_t  wr_index,
    input  icache_pkg::offset_t wr_offset,
    input  icache_pkg::word_t   wr_word
);
    localparam int DEPTH = `ICACHE_LINES * `ICACHE_WORDS;
    localparam int AW    = $bits(icache_pkg::index_t) + $bits(icache_pkg::offset_t);

    icache_pkg::word_t words [DEPTH];
    logic [AW-1:0]     rd_addr;
    logic [AW-1:0]     wr_addr;

    // line index on top, word within line below
    assign rd_addr = {rd_index, rd_offset};
    assign wr_addr = {wr_index, wr_offset};

    always_ff @(posedge clk)
    begin
        rd_data <= words[rd_addr];
        if (wr_en)
            words[wr_addr] <= wr_word;
    end

endmodule

`default_nettype wire

/* src/icache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none
`include "icache_config.svh"

module icache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  icache_pkg::fetch_req_t  fetch_req,
    output icache_pkg::fetch_resp_t fetch_resp,
    output icache_pkg::mem_req_t    mem_req,
    input  icache_pkg::mem_resp_t   mem_resp,
    input  logic                    flush,
    input  logic                    hit,
    input  icache_pkg::word_t       rd_data,
    output icache_pkg::index_t      rd_index,
    output icache_pkg::offset_t     rd_offset,
    output icache_pkg::tag_t        req_tag,
    output logic                    wr_en,
    output icache_pkg::offset_t     wr_offset,
    output icache_pkg::word_t       wr_word,
    output logic                    tag_wr,
    output logic                    clear_all
);
    localparam int OFF_LSB = `ICACHE_BYTE_BITS;
    localparam int IDX_LSB = OFF_LSB + $bits(icache_pkg::offset_t);
    localparam int TAG_LSB = IDX_LSB + $bits(icache_pkg::index_t);
    localparam icache_pkg::offset_t LAST_BEAT = icache_pkg::offset_t'(`ICACHE_WORDS - 1);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t state_next;
    icache_pkg::word_t       req_addr;
    icache_pkg::index_t      held_index;
    icache_pkg::offset_t     held_offset;
    icache_pkg::offset_t     beat;
    logic                    mem_valid;
    logic                    beat_done;
    logic                    resp_ready;
    icache_pkg::word_t       resp_data;

    assign held_index  = req_addr[TAG_LSB-1:IDX_LSB];
    assign held_offset = req_addr[IDX_LSB-1:OFF_LSB];
    assign req_tag     = req_addr[`ICACHE_ADDR_W-1:TAG_LSB];

    // arrays are read on the edge leaving IDLE, before the address is held
    assign rd_index  = (state == icache_pkg::IDLE) ? fetch_req.addr[TAG_LSB-1:IDX_LSB]
                                                   : held_index;
    assign rd_offset = (state == icache_pkg::IDLE) ? fetch_req.addr[IDX_LSB-1:OFF_LSB]
                                                   : held_offset;

    assign beat_done = mem_valid && mem_resp.ready;

    always_comb
    begin
        state_next = state;
        case (state)
            icache_pkg::IDLE:
                // ignore the request still held during its own ready cycle
                if (flush)
                    state_next = icache_pkg::FLUSH;
                else if (fetch_req.valid && !resp_ready)
                    state_next = icache_pkg::LOOKUP;
            icache_pkg::LOOKUP:
                state_next = hit ? icache_pkg::IDLE : icache_pkg::REFILL;
            icache_pkg::REFILL:
                // one settle cycle after the last beat so the new tag is read
                if (!mem_valid)
                    state_next = icache_pkg::LOOKUP;
            icache_pkg::FLUSH:
                state_next = icache_pkg::IDLE;
            default:
                state_next = icache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= icache_pkg::IDLE;
            mem_valid  <= 1'b0;
            beat       <= '0;
            resp_ready <= 1'b0;
        end
        else
        begin
            state      <= state_next;
            resp_ready <= (state == icache_pkg::LOOKUP) && hit;
            if (state == icache_pkg::LOOKUP && !hit)
                mem_valid <= 1'b1;
            else if (beat_done && beat == LAST_BEAT)
                mem_valid <= 1'b0;
            if (beat_done)
                beat <= beat + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == icache_pkg::IDLE)
            req_addr <= fetch_req.addr;
        if (state == icache_pkg::LOOKUP && hit)
            resp_data <= rd_data;
    end

    assign mem_req = '{valid: mem_valid,
                       addr: {req_tag, held_index, beat, {`ICACHE_BYTE_BITS{1'b0}}}};
    assign fetch_resp = '{ready: resp_ready, data: resp_data};

    assign wr_en     = beat_done;
    assign wr_offset = beat;
    assign wr_word   = mem_resp.data;
    assign tag_wr    = beat_done && (beat == LAST_BEAT);
    assign clear_all = (state == icache_pkg::FLUSH);

endmodule

`default_nettype wire

/* src/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  icache_pkg::fetch_req_t  fetch_req,
    output icache_pkg::fetch_resp_t fetch_resp,
    output icache_pkg::mem_req_t    mem_req,
    input  icache_pkg::mem_resp_t   mem_resp
);
    icache_pkg::index_t  rd_index;
    icache_pkg::offset_t rd_offset;
    icache_pkg::tag_t    req_tag;
    icache_pkg::word_t   rd_data;
    logic                hit;
    logic                wr_en;
    icache_pkg::offset_t wr_offset;
    icache_pkg::word_t   wr_word;
    logic                tag_wr;
    logic                clear_all;

    icache_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp),
        .flush      (flush),
        .hit        (hit),
        .rd_data    (rd_data),
        .rd_index   (rd_index),
        .rd_offset  (rd_offset),
        .req_tag    (req_tag),
        .wr_en      (wr_en),
        .wr_offset  (wr_offset),
        .wr_word    (wr_word),
        .tag_wr     (tag_wr),
        .clear_all  (clear_all)
    );

    icache_tag_array u_tags (
        .clk       (clk),
        .rst       (rst),
        .rd_index  (rd_index),
        .req_tag   (req_tag),
        .tag_wr    (tag_wr),
        .clear_all (clear_all),
        .hit       (hit)
    );

    // refill always targets the line being looked up
    icache_data_array u_data (
        .clk       (clk),
        .rd_index  (rd_index),
        .rd_offset (rd_offset),
        .rd_data   (rd_data),
        .wr_en     (wr_en),
        .wr_index  (rd_index),
        .wr_offset (wr_offset),
        .wr_word   (wr_word)
    );

endmodule

`default_nettype wire

/* tb/icache_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_asserts (
    input logic                    clk,
    input logic                    rst,
    input icache_pkg::fetch_req_t  fetch_req,
    input icache_pkg::fetch_resp_t fetch_resp,
    input icache_pkg::mem_req_t    mem_req,
    input icache_pkg::mem_resp_t   mem_resp
);
    int fail_count = 0;

    // memory stall holds the beat steady
    mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_req.valid && !mem_resp.ready |=> mem_req.valid && $stable(mem_req.addr))
    else
    begin
        fail_count++;
        $error("memory request dropped or changed before ready");
    end

    // ready answers a request that was present at the edge raising it
    ready_with_valid: assert property (@(posedge clk) disable iff (rst)
        $rose(fetch_resp.ready) |-> $past(fetch_req.valid))
    else
    begin
        fail_count++;
        $error("fetch ready raised without a fetch request");
    end

    ready_pulse: assert property (@(posedge clk) disable iff (rst)
        fetch_resp.ready |=> !fetch_resp.ready)
    else
    begin
        fail_count++;
        $error("fetch ready held longer than one cycle");
    end

    reset_quiet: assert property (@(posedge clk)
        rst |=> !mem_req.valid && !fetch_resp.ready)
    else
    begin
        fail_count++;
        $error("memory valid or fetch ready set after reset");
    end

endmodule

bind icache_top icache_asserts u_asserts (
    .clk        (clk),
    .rst        (rst),
    .fetch_req  (fetch_req),
    .fetch_resp (fetch_resp),
    .mem_req    (mem_req),
    .mem_resp   (mem_resp)
);

`default_nettype wire

/* tb/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    localparam int FETCH_LIMIT = 200;
    localparam int RUN_LIMIT   = 100000;

    logic                    clk;
    logic                    rst;
    logic                    flush;
    icache_pkg::fetch_req_t  fetch_req;
    icache_pkg::fetch_resp_t fetch_resp;
    icache_pkg::mem_req_t    mem_req;
    icache_pkg::mem_resp_t   mem_resp;

    icache_pkg::word_t beat_log [$];
    bit                model_valid [64];
    icache_pkg::tag_t  model_tag [64];
    int                word_errors = 0;
    int                flag_errors = 0;
    int                timeouts = 0;
    bit                stim_done = 1'b0;

    icache_top dut (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .mem_req    (mem_req),
        .mem_resp   (mem_resp)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory contents and thus the expected word of every fetch
    function automatic icache_pkg::word_t ref_word(input icache_pkg::word_t addr);
        icache_pkg::word_t x;
        logic [4:0]        sh;
        x  = addr ^ 32'h5a3c_96e1;
        sh = addr[6:2];
        return (x << sh) | (x >> (6'd32 - {1'b0, sh}));
    endfunction

    // byte bits 1:0, word 3:2, line 9:4, tag above
    function automatic icache_pkg::index_t line_index(input icache_pkg::word_t addr);
        return addr[9:4];
    endfunction

    function automatic icache_pkg::tag_t line_tag(input icache_pkg::word_t addr);
        return addr[31:10];
    endfunction

    task automatic check_word(input string name, input icache_pkg::word_t got,
                              input icache_pkg::word_t exp);
        if (got !== exp)
        begin
            word_errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            flag_errors++;
            $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // memory answers each beat after 0 to 5 cycles
    initial
    begin : memory_model
        int delay_left;
        bit busy;
        mem_resp   = '0;
        delay_left = 0;
        busy       = 1'b0;
        forever
        begin
            @(negedge clk);
            mem_resp.ready = 1'b0;
            if (!rst && mem_req.valid)
            begin
                if (!busy)
                begin
                    busy       = 1'b1;
                    delay_left = $urandom_range(5, 0);
                end
                if (delay_left == 0)
                begin
                    mem_resp.ready = 1'b1;
                    mem_resp.data  = ref_word(mem_req.addr);
                    beat_log.push_back(mem_req.addr);
                    busy = 1'b0;
                end
                else
                    delay_left--;
            end
        end
    end

    task automatic do_fetch(input icache_pkg::word_t addr, output icache_pkg::word_t data,
                            output int cycles);
        beat_log.delete();
        fetch_req = '{valid: 1'b1, addr: addr};
        cycles = 0;
        do
        begin
            @(negedge clk);
            cycles++;
        end
        while (!fetch_resp.ready && cycles < FETCH_LIMIT);
        if (!fetch_resp.ready)
        begin
            timeouts++;
            $display("no fetch ready for address %h within %0d cycles", addr, FETCH_LIMIT);
        end
        data = fetch_resp.data;
        fetch_req.valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic fetch_and_check(input icache_pkg::word_t addr);
        icache_pkg::word_t  data;
        icache_pkg::word_t  base;
        icache_pkg::index_t idx;
        int                 cycles;
        logic               exp_miss;
        idx      = line_index(addr);
        exp_miss = !(model_valid[idx] && model_tag[idx] == line_tag(addr));
        base     = addr & 32'hffff_fff0;
        do_fetch(addr, data, cycles);
        if (timeouts == 0)
        begin
            check_word("fetch_resp.data", data, ref_word(addr));
            check_flag("mem_req.valid seen", beat_log.size() != 0, exp_miss);
            if (exp_miss)
            begin
                check_flag("refill of four beats", beat_log.size() == 4, 1'b1);
                foreach (beat_log[i])
                    check_word("mem_req.addr", beat_log[i], base | (icache_pkg::word_t'(i) << 2));
            end
            else
                check_flag("fetch_resp.ready two edges after valid", cycles == 2, 1'b1);
        end
        model_valid[idx] = 1'b1;
        model_tag[idx]   = line_tag(addr);
    endtask

    task automatic pulse_flush;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        @(negedge clk);
        foreach (model_valid[i])
            model_valid[i] = 1'b0;
    endtask

    initial
    begin : stimulus
        icache_pkg::word_t a;
        icache_pkg::word_t b;
        icache_pkg::word_t r;
        void'($urandom(32'hc997));
        rst       = 1'b1;
        flush     = 1'b0;
        fetch_req = '0;
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // cold miss, then the rest of the line
        a = 32'h0000_4a18;
        fetch_and_check(a);
        for (int o = 0; o < 4; o++)
        begin
            if (o != 2)
                fetch_and_check((a & 32'hffff_fff0) | (icache_pkg::word_t'(o) << 2));
        end

        // same line index, other tag
        b = a ^ 32'h0001_0000;
        repeat (2)
        begin
            fetch_and_check(b);
            fetch_and_check(a);
        end

        fetch_and_check(a);
        pulse_flush();
        fetch_and_check(a);

        // three tags over four lines
        repeat (300)
        begin
            r = 32'h0002_0000
                | (icache_pkg::word_t'($urandom_range(2, 0)) << 10)
                | (icache_pkg::word_t'($urandom_range(3, 0)) << 4)
                | (icache_pkg::word_t'($urandom_range(3, 0)) << 2);
            fetch_and_check(r);
        end
        stim_done = 1'b1;
    end

    initial
    begin : report
        int cycles;
        int total;
        cycles = 0;
        while (!stim_done && timeouts == 0 && cycles < RUN_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!stim_done && timeouts == 0)
        begin
            timeouts++;
            $display("run did not finish within %0d cycles", RUN_LIMIT);
        end
        total = word_errors + flag_errors + timeouts + dut.u_asserts.fail_count;
        $display("errors: %0d word, %0d flag, %0d timeout, %0d assertion",
                 word_errors, flag_errors, timeouts, dut.u_asserts.fail_count);
        if (total == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

/* icache_top.f */
+incdir+src
src/icache_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_ctrl.sv
src/icache_top.sv
tb/icache_asserts.sv
tb/icache_tb.sv

/* Makefile */
TOP = icache_tb

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f icache_top.f -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	! grep -q "=== FAIL ===" sim.log && grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
